// ==== bench/prefetch_chk.sv ====
// bus protocol and FIFO overflow assertions, bound into the FIFO and the controller
// inputs a binding does not use are tied low, so those properties stay idle there
`timescale 1ns/10ps

module prefetch_chk (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         clear_i,
  input logic                         in_valid_i,
  input logic                         last_full_i,
  input logic                         mem_req_i,
  input logic                         mem_gnt_i,
  input logic [fetch_pkg::addr_w-1:0] mem_addr_i
);

  // failed assertions so far
  int unsigned error_count = 0;

  // a word must never arrive with the last entry taken, a flush drops it anyway
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i && !clear_i |-> !last_full_i)
  else begin
    $error("fetch FIFO written while its last entry is full");
    error_count++;
  end

  // request held until granted
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i && !mem_gnt_i |=> mem_req_i)
  else begin
    $error("mem_req dropped before mem_gnt");
    error_count++;
  end

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i && !mem_gnt_i |=> $stable(mem_addr_i))
  else begin
    $error("mem_addr changed while the request waited for its grant");
    error_count++;
  end

endmodule

bind fetch_fifo prefetch_chk u_fifo_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .clear_i     (clear_i),
  .in_valid_i  (in_valid_i),
  .last_full_i (valid_q[fetch_pkg::fifo_depth-1]),
  .mem_req_i   (1'b0),
  .mem_gnt_i   (1'b0),
  .mem_addr_i  ('0)
);

bind fetch_req_ctrl prefetch_chk u_req_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .clear_i     (1'b0),
  .in_valid_i  (1'b0),
  .last_full_i (1'b0),
  .mem_req_i   (mem_req_o),
  .mem_gnt_i   (mem_gnt_i),
  .mem_addr_i  (mem_addr_o)
);

// ==== bench/prefetch_tb.sv ====
// random-latency memory of 256 words, addresses wrap every 1 KiB
// branch targets stay halfword aligned, the DUT does not check bit 0
`timescale 1ns/10ps

module prefetch_tb;

  localparam int unsigned num_tests   = 5;
  localparam int unsigned instr_count = 200;
  // about 10 cycles per instruction at worst, plus margin
  localparam int unsigned max_cycles  = num_tests * instr_count * 10 + 2000;

  logic        clk;
  logic        rst_n;
  logic        fetch_en_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        instr_ready_i;
  logic        instr_valid_o;
  logic [31:0] instr_rdata_o;
  logic [31:0] instr_addr_o;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_gnt_i    = 1'b0;
  logic        mem_rvalid_i = 1'b0;
  logic [31:0] mem_rdata_i  = 32'd0;

  integer      seed = 32'h321b;
  logic [31:0] mem [256];

  // memory model state
  logic        gnt_busy = 1'b0;
  int unsigned gnt_wait = 0;
  logic        rsp_busy = 1'b0;
  int unsigned rsp_wait = 0;
  logic [31:0] rsp_addr = 32'd0;
  // granted request not yet answered, seen at the rising edge
  logic        resp_pending = 1'b0;

  // reference model
  logic [31:0] exp_pc     = 32'd0;
  logic [31:0] last_addr  = 32'd0;
  int unsigned xfer_count = 0;

  string       test_name;
  int unsigned test_errors  = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;
  int unsigned cycle_count  = 0;
  int unsigned chk_errors;
  logic [31:0] target;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  prefetch_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_rdata_o (instr_rdata_o),
    .instr_addr_o  (instr_addr_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  function automatic logic [31:0] rand_below(input logic [31:0] n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // halfword at a byte address, memory wraps
  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] word;
    word = mem[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  always @(negedge clk) begin
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    if (rsp_busy) begin
      if (rsp_wait == 0) begin
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = mem[rsp_addr[9:2]];
        rsp_busy     = 1'b0;
      end else begin
        rsp_wait--;
      end
    end
    if (mem_req_o && !rsp_busy) begin
      // grant after 0 to 3 cycles
      if (!gnt_busy) begin
        gnt_busy = 1'b1;
        gnt_wait = rand_below(4);
      end
      if (gnt_wait == 0) begin
        mem_gnt_i = 1'b1;
        gnt_busy  = 1'b0;
        rsp_busy  = 1'b1;
        // response 1 to 3 cycles after the grant
        rsp_wait  = rand_below(3);
        rsp_addr  = mem_addr_o;
      end else begin
        gnt_wait--;
      end
    end
  end

  //////////////////////////////
  // reference model, monitor
  //////////////////////////////

  always @(posedge clk) begin
    logic [15:0] low_half;
    logic [31:0] exp_data;
    logic [31:0] mask;
    int unsigned step;
    if (mem_gnt_i) begin
      resp_pending = 1'b1;
    end else if (mem_rvalid_i) begin
      resp_pending = 1'b0;
    end
    if (rst_n && instr_valid_o && instr_ready_i) begin
      low_half = half_at(exp_pc);
      // 2'b11 in the low bits marks a full-length instruction
      if (low_half[1:0] == 2'b11) begin
        exp_data = {half_at(exp_pc + 32'd2), low_half};
        mask     = 32'hffff_ffff;
        step     = 4;
      end else begin
        exp_data = {16'h0000, low_half};
        mask     = 32'h0000_ffff;
        step     = 2;
      end
      check_value("address", exp_pc, instr_addr_o);
      check_value("data", exp_data, instr_rdata_o & mask);
      last_addr = instr_addr_o;
      exp_pc    = exp_pc + step;
      xfer_count++;
    end
    // stream restarts at the target after this edge
    if (branch_i) begin
      exp_pc = branch_addr_i;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  // one-cycle branch, entered and left on a falling edge
  task automatic drive_branch(input logic [31:0] addr);
    branch_i      = 1'b1;
    branch_addr_i = addr;
    @(negedge clk);
    branch_i      = 1'b0;
  endtask

  // runs until n more instructions transferred
  // branch_pm is per mille per cycle, four times higher while the memory is busy
  task automatic run_instrs(input int unsigned n, input int unsigned ready_pct,
                            input int unsigned branch_pm);
    int unsigned goal;
    int unsigned rate;
    goal = xfer_count + n;
    while (xfer_count < goal) begin
      instr_ready_i = rand_below(100) < ready_pct;
      rate = (resp_pending || mem_req_o) ? branch_pm * 4 : branch_pm;
      if (rand_below(1000) < rate) begin
        branch_i      = 1'b1;
        branch_addr_i = rand_below(512) << 1;
      end else begin
        branch_i = 1'b0;
      end
      @(negedge clk);
    end
    branch_i = 1'b0;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = 32'd0;
    instr_ready_i = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = $random(seed);
    end

    start_test("reset_state");
    repeat (5) begin
      @(negedge clk);
      check_value("instr_valid_o", 32'd0, {31'd0, instr_valid_o});
      check_value("mem_req_o", 32'd0, {31'd0, mem_req_o});
    end
    rst_n = 1'b1;
    // fetch still disabled, nothing may move
    repeat (3) begin
      @(negedge clk);
      check_value("instr_valid_o", 32'd0, {31'd0, instr_valid_o});
      check_value("mem_req_o", 32'd0, {31'd0, mem_req_o});
    end
    finish_test();

    start_test("aligned_start");
    fetch_en_i    = 1'b1;
    instr_ready_i = 1'b1;
    @(negedge clk);
    check_value("mem_req_o", 32'd1, {31'd0, mem_req_o});
    check_value("mem_addr_o", 32'd0, mem_addr_o);
    run_instrs(instr_count, 100, 0);
    finish_test();

    start_test("unaligned_branch");
    target = (rand_below(256) << 2) | 32'd2;
    drive_branch(target);
    run_instrs(1, 100, 0);
    check_value("first address", target, last_addr);
    run_instrs(instr_count - 1, 100, 0);
    finish_test();

    start_test("back_pressure");
    run_instrs(instr_count, 50, 0);
    finish_test();

    start_test("branch_mid_stream");
    run_instrs(instr_count, 75, 8);
    finish_test();

    chk_errors = dut.u_fifo.u_fifo_chk.error_count + dut.u_req.u_req_chk.error_count;
    $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, chk_errors);
    if (tests_failed == 0 && chk_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
design/fetch_pkg.sv
design/isa_pkg.sv
design/fetch_fifo.sv
design/fetch_req_ctrl.sv
design/prefetch_top.sv
bench/prefetch_chk.sv
bench/prefetch_tb.sv

// ==== design/fetch_fifo.sv ====
// word buffer with aligner; a word written into an empty buffer shows up at the output at once
// clear_i empties the buffer for the next cycle and drops any input of that cycle
`timescale 1ns/10ps

module fetch_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear_i,
  input  logic [fetch_pkg::addr_w-1:0] in_addr_i,
  input  logic [fetch_pkg::addr_w-1:0] in_rdata_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [fetch_pkg::addr_w-1:0] out_rdata_o,
  output logic [fetch_pkg::addr_w-1:0] out_addr_o
);

  // stored entries, entry 0 feeds the output
  logic [fetch_pkg::addr_w-1:0]     addr_q   [fetch_pkg::fifo_depth];
  logic [fetch_pkg::addr_w-1:0]     rdata_q  [fetch_pkg::fifo_depth];
  logic [fetch_pkg::fifo_depth-1:0] valid_q;

  // contents after the input word is written
  logic [fetch_pkg::addr_w-1:0]     addr_wr  [fetch_pkg::fifo_depth];
  logic [fetch_pkg::addr_w-1:0]     rdata_wr [fetch_pkg::fifo_depth];
  logic [fetch_pkg::fifo_depth-1:0] valid_wr;
  logic                             found;

  // contents after the output transfer
  logic [fetch_pkg::addr_w-1:0]     addr_d   [fetch_pkg::fifo_depth];
  logic [fetch_pkg::addr_w-1:0]     rdata_d  [fetch_pkg::fifo_depth];
  logic [fetch_pkg::fifo_depth-1:0] valid_d;

  // head word, from entry 0 or bypassed from the input
  logic [fetch_pkg::addr_w-1:0]     head_rdata;
  logic                             head_valid;
  // upper half of the head word joined with the lower half of the next one
  logic [fetch_pkg::addr_w-1:0]     split_rdata;
  logic                             split_valid;

  isa_pkg::ilen_e                   out_len;
  logic                             used_up;
  logic [fetch_pkg::addr_w-1:0]     next_word;

  //////////////////////////////
  // output side
  //////////////////////////////

  assign head_rdata = valid_q[0] ? rdata_q[0] : in_rdata_i;
  assign head_valid = valid_q[0] | in_valid_i;

  // second half comes from entry 1 if stored, else straight from the input
  assign split_rdata = valid_q[1] ? {rdata_q[1][15:0], head_rdata[31:16]}
                                  : {in_rdata_i[15:0], head_rdata[31:16]};
  // entries fill from 0 upwards, so entry 1 implies entry 0
  assign split_valid = valid_q[1] | (valid_q[0] & in_valid_i);

  assign out_addr_o  = valid_q[0] ? addr_q[0] : in_addr_i;
  assign out_rdata_o = out_addr_o[1] ? split_rdata : head_rdata;

  // low bits of the output are the instruction's low bits in both cases
  assign out_len = (out_rdata_o[1:0] == isa_pkg::full_len_code) ? isa_pkg::ILEN_32
                                                                 : isa_pkg::ILEN_16;

  // only an unaligned 32-bit instruction needs two words
  assign out_valid_o = (out_addr_o[1] && out_len == isa_pkg::ILEN_32) ? split_valid
                                                                      : head_valid;

  //////////////////////////////
  // input side
  //////////////////////////////

  // one request in flight, so one free slot beyond this is enough
  assign in_ready_o = ~valid_q[fetch_pkg::fifo_depth-2];

  // incoming word goes to the lowest free entry
  always_comb begin
    addr_wr  = addr_q;
    rdata_wr = rdata_q;
    valid_wr = valid_q;
    found    = 1'b0;
    for (int i = 0; i < fetch_pkg::fifo_depth; i++) begin
      if (in_valid_i && !valid_q[i] && !found) begin
        addr_wr[i]  = in_addr_i;
        rdata_wr[i] = in_rdata_i;
        valid_wr[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  //////////////////////////////
  // transfer and shift
  //////////////////////////////

  // head word is consumed by any unaligned instruction or an aligned 32-bit one
  assign used_up   = addr_wr[0][1] || out_len == isa_pkg::ILEN_32;
  assign next_word = {addr_wr[0][fetch_pkg::addr_w-1:2], 2'b00} + 32'd4;

  always_comb begin
    addr_d  = addr_wr;
    rdata_d = rdata_wr;
    valid_d = valid_wr;
    if (out_valid_o && out_ready_i) begin
      if (used_up) begin
        for (int i = 0; i < fetch_pkg::fifo_depth - 1; i++) begin
          addr_d[i]  = addr_wr[i+1];
          rdata_d[i] = rdata_wr[i+1];
          valid_d[i] = valid_wr[i+1];
        end
        valid_d[fetch_pkg::fifo_depth-1] = 1'b0;
        // unaligned 32-bit ate half of the next word too
        if (addr_wr[0][1] && out_len == isa_pkg::ILEN_32) begin
          addr_d[0] = {next_word[fetch_pkg::addr_w-1:2], 2'b10};
        end else begin
          addr_d[0] = next_word;
        end
      end else begin
        // aligned compressed, stay on this word at its upper half
        addr_d[0] = {addr_wr[0][fetch_pkg::addr_w-1:2], 2'b10};
      end
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      // flush for a branch, input of this cycle belongs to the old stream
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // payload only matters where the matching valid bit is set
  always_ff @(posedge clk) begin
    addr_q  <= addr_d;
    rdata_q <= rdata_d;
  end

endmodule

// ==== design/fetch_pkg.sv ====
// fetch buffer geometry and request controller states
// fifo_depth below 3 stalls unaligned 32-bit instructions for good
package fetch_pkg;

  //////////////////////////////
  // buffer geometry
  //////////////////////////////

  // word entries in the fetch FIFO
  localparam int unsigned fifo_depth = 3;

  // address and data width of the memory port
  localparam int unsigned addr_w = 32;

  //////////////////////////////
  // request FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    REQ_IDLE,        // fetching disabled or buffer full
    REQ_WAIT_GNT,    // request held until granted
    REQ_WAIT_RVALID  // granted, response pending
  } req_state_e;

endpackage

// ==== design/fetch_req_ctrl.sv ====
// one word request in flight; the memory must respond at least one cycle after the grant
// branch_addr_i must be halfword aligned, bit 0 is passed through unchecked
`timescale 1ns/10ps

module fetch_req_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fetch_en_i,
  input  logic                         branch_i,
  input  logic [fetch_pkg::addr_w-1:0] branch_addr_i,
  output logic                         mem_req_o,
  output logic [fetch_pkg::addr_w-1:0] mem_addr_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [fetch_pkg::addr_w-1:0] mem_rdata_i,
  output logic                         fifo_valid_o,
  output logic [fetch_pkg::addr_w-1:0] fifo_addr_o,
  output logic [fetch_pkg::addr_w-1:0] fifo_rdata_o,
  output logic                         fifo_clear_o,
  input  logic                         fifo_ready_i
);

  fetch_pkg::req_state_e        state_q, state_d;
  // next word to request, keeps bit 1 of a branch target
  logic [fetch_pkg::addr_w-1:0] fetch_addr_q, fetch_addr_d;
  // word address on the memory port
  logic [fetch_pkg::addr_w-1:0] req_addr_q;
  // address handed to the FIFO with the response
  logic [fetch_pkg::addr_w-1:0] resp_addr_q;
  // outstanding request belongs to the stream before a branch
  logic                         stale_q, stale_d;
  logic                         issue;
  logic                         resp_done;
  logic [fetch_pkg::addr_w-1:0] issue_addr;

  assign resp_done  = (state_q == fetch_pkg::REQ_WAIT_RVALID) && mem_rvalid_i;
  // a branch cycle may already issue for its target
  assign issue_addr = branch_i ? branch_addr_i : fetch_addr_q;

  //////////////////////////////
  // request FSM
  //////////////////////////////

  // buffer is flushed by a branch, so its ready does not matter then
  always_comb begin
    state_d = state_q;
    issue   = 1'b0;
    case (state_q)
      fetch_pkg::REQ_IDLE: begin
        if (fetch_en_i && (fifo_ready_i || branch_i)) begin
          state_d = fetch_pkg::REQ_WAIT_GNT;
          issue   = 1'b1;
        end
      end
      fetch_pkg::REQ_WAIT_GNT: begin
        // held even across a branch, the bus protocol wants it
        if (mem_gnt_i) begin
          state_d = fetch_pkg::REQ_WAIT_RVALID;
        end
      end
      fetch_pkg::REQ_WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          if (fetch_en_i && (fifo_ready_i || branch_i)) begin
            state_d = fetch_pkg::REQ_WAIT_GNT;
            issue   = 1'b1;
          end else begin
            state_d = fetch_pkg::REQ_IDLE;
          end
        end
      end
      default: state_d = fetch_pkg::REQ_IDLE;
    endcase
  end

  //////////////////////////////
  // stale tracking, address
  //////////////////////////////

  // anything outstanding past the branch cycle is old
  always_comb begin
    stale_d = stale_q;
    if (branch_i) begin
      stale_d = (state_q == fetch_pkg::REQ_WAIT_GNT) ||
                (state_q == fetch_pkg::REQ_WAIT_RVALID && !mem_rvalid_i);
    end else if (resp_done) begin
      stale_d = 1'b0;
    end
  end

  // counter moves on a granted request of the current stream
  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (branch_i) begin
      fetch_addr_d = branch_addr_i;
    end else if (state_q == fetch_pkg::REQ_WAIT_GNT && mem_gnt_i && !stale_q) begin
      fetch_addr_d = req_addr_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::REQ_IDLE;
      fetch_addr_q <= '0;
      stale_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
      stale_q      <= stale_d;
    end
  end

  // captured once per request, read only while it is outstanding
  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr_q  <= {issue_addr[fetch_pkg::addr_w-1:2], 2'b00};
      resp_addr_q <= issue_addr;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign mem_req_o    = state_q == fetch_pkg::REQ_WAIT_GNT;
  assign mem_addr_o   = req_addr_q;
  // a response in the branch cycle is dropped with the flush
  assign fifo_valid_o = resp_done && !stale_q && !branch_i;
  assign fifo_addr_o  = resp_addr_q;
  assign fifo_rdata_o = mem_rdata_i;
  assign fifo_clear_o = branch_i;

endmodule

// ==== design/isa_pkg.sv ====
// instruction encoding constants for RV32 with the C extension
// only the length rule is covered here, no opcode decoding
package isa_pkg;

  //////////////////////////////
  // length encoding
  //////////////////////////////

  // lowest two bits of a full 32-bit instruction
  // any other value marks a 16-bit compressed one
  localparam logic [1:0] full_len_code = 2'b11;

  // instruction length as seen by the aligner
  typedef enum logic {
    ILEN_16,
    ILEN_32
  } ilen_e;

endpackage

// ==== design/prefetch_top.sv ====
// prefetch unit, memory request side and instruction side
// instr_rdata_o bits 31:16 are junk for a compressed instruction
`timescale 1ns/10ps

module prefetch_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // decoder side
  input  logic                         fetch_en_i,
  input  logic                         branch_i,
  input  logic [fetch_pkg::addr_w-1:0] branch_addr_i,
  output logic                         instr_valid_o,
  input  logic                         instr_ready_i,
  output logic [fetch_pkg::addr_w-1:0] instr_rdata_o,
  output logic [fetch_pkg::addr_w-1:0] instr_addr_o,
  // instruction memory side
  output logic                         mem_req_o,
  output logic [fetch_pkg::addr_w-1:0] mem_addr_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [fetch_pkg::addr_w-1:0] mem_rdata_i
);

  // controller to buffer
  logic                         fifo_valid;
  logic [fetch_pkg::addr_w-1:0] fifo_addr;
  logic [fetch_pkg::addr_w-1:0] fifo_rdata;
  logic                         fifo_clear;
  logic                         fifo_ready;

  fetch_req_ctrl u_req (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .fifo_valid_o  (fifo_valid),
    .fifo_addr_o   (fifo_addr),
    .fifo_rdata_o  (fifo_rdata),
    .fifo_clear_o  (fifo_clear),
    .fifo_ready_i  (fifo_ready)
  );

  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (fifo_clear),
    .in_addr_i   (fifo_addr),
    .in_rdata_i  (fifo_rdata),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .out_valid_o (instr_valid_o),
    .out_ready_i (instr_ready_i),
    .out_rdata_o (instr_rdata_o),
    .out_addr_o  (instr_addr_o)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the prefetch testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=prefetch_sim
log_file=sim.log

verilator --binary --assert --timescale 1ns/10ps \
  --top-module prefetch_tb -f compile.f --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log_file"; then
  echo "run_sim: testbench reported success"
  exit 0
fi
echo "run_sim: pass line not found in $log_file"
exit 1
